/* src.f */
common/tcb_pkg.sv
common/tcb_ben_pkg.sv
verilog/tcb_dly_line.sv
tcb_conv/tcb_logsize2byteena.sv
tcb_mem/tcb_mem_ben.sv
verilog/tcb_mem_sys.sv
tb/tcb_clk_gen.sv
tb/tcb_mem_sys_tb.sv

/* Makefile */
TOP := tcb_mem_sys_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	verilator --lint-only --timing --assert -Wall -f src.f --top-module tcb_mem_sys

clean:
	rm -rf obj_dir

/* tb/tcb_mem_sys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tcb_mem_sys_tb;

  localparam int unsigned HSK_DLY   = 2;
  localparam int unsigned MEM_DEPTH = 16;
  localparam int unsigned RST_CYC   = 16;
  // reset, clearing, tests and drain
  localparam int unsigned CYC_MAX   = RST_CYC + MEM_DEPTH + 300 + HSK_DLY;
  localparam int unsigned IDX_W     = $clog2(MEM_DEPTH);

  // expected response and the rising edge it is due on
  typedef struct packed {
    logic [31:0]       due;
    tcb_pkg::tcb_rsp_t rsp;
  } exp_rsp_t;

  logic              clk;
  logic              arst_n;
  logic              vld;
  tcb_pkg::tcb_req_t req;
  logic              rdy;
  tcb_pkg::tcb_rsp_t rsp;

  int unsigned       cyc = 0;
  int unsigned       rel_cnt;
  int unsigned       errors = 0;
  int unsigned       xfer_cnt = 0;
  int unsigned       rsp_cnt = 0;
  string             test_name = "reset";
  logic [15:0]       lfsr;
  // reference memory, one entry per byte address
  logic [7:0]        ref_mem [MEM_DEPTH*4];
  exp_rsp_t          exp_q [$];
  // expectation for the coming rising edge
  logic              exp_vld = 1'b0;
  tcb_pkg::tcb_rsp_t exp_rsp;

  tcb_clk_gen #(.PERIOD_NS(100), .RST_CYC(RST_CYC)) tcb_clk_gen_i (.clk, .arst_n);

  tcb_mem_sys #(.HSK_DLY(HSK_DLY), .MEM_DEPTH(MEM_DEPTH)) tcb_mem_sys_i (.*);

  ////////////////////
  // counters
  ////////////////////

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (rsp.vld) begin
      rsp_cnt <= rsp_cnt + 1;
    end
    if (cyc >= CYC_MAX) begin
      $display("timeout: run still busy after %0d cycles", CYC_MAX);
      finish_run(1'b1);
    end
  end

  // cycles since reset release, saturating
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rel_cnt <= 0;
    end else if (rel_cnt < MEM_DEPTH) begin
      rel_cnt <= rel_cnt + 1;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // reset reaches the flops on the first edge at the latest
  a_rst_low: assert property (@(posedge clk) (!arst_n && cyc > 0) |-> (!rdy && !rsp.vld))
    else begin
      errors++;
      $display("ERROR %s: rdy/rsp.vld expected 0/0, actual %0b/%0b",
               test_name, $sampled(rdy), $sampled(rsp.vld));
    end

  // clearing sweep takes exactly MEM_DEPTH cycles
  a_rdy_clear: assert property (@(posedge clk) arst_n |-> (rdy == (rel_cnt >= MEM_DEPTH)))
    else begin
      errors++;
      $display("ERROR %s: rdy expected %0b, actual %0b",
               test_name, $sampled(rel_cnt) >= MEM_DEPTH, $sampled(rdy));
    end

  // also catches early, late and extra responses
  a_rsp_vld: assert property (@(posedge clk) disable iff (!arst_n) rsp.vld == exp_vld)
    else begin
      errors++;
      $display("ERROR %s: rsp.vld expected %0b, actual %0b",
               test_name, $sampled(exp_vld), $sampled(rsp.vld));
    end

  a_rsp_dat: assert property (@(posedge clk) disable iff (!arst_n)
    exp_vld |-> (rsp.rdt == exp_rsp.rdt && rsp.sts == exp_rsp.sts))
    else begin
      errors++;
      $display("ERROR %s: rdt/sts expected %08h/%0d, actual %08h/%0d", test_name,
               $sampled(exp_rsp.rdt), $sampled(exp_rsp.sts),
               $sampled(rsp.rdt), $sampled(rsp.sts));
    end

  ////////////////////
  // helpers
  ////////////////////

  // fibonacci lfsr x^16+x^14+x^13+x^11+1, one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[15]};
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    end
    return v;
  endfunction

  // reference access: read old word, write sized bytes, pick lanes
  function automatic tcb_pkg::tcb_rsp_t model_access(input tcb_pkg::tcb_req_t r);
    tcb_pkg::tcb_rsp_t res;
    logic [31:0]       wrd;
    logic [1:0]        off;
    logic [1:0]        hlf;
    int unsigned       base;
    wrd = r.adr >> 2;
    off = r.adr[1:0];
    hlf = off & 2'b10;
    base = wrd * 4;
    res.vld = 1'b1;
    if (wrd >= MEM_DEPTH) begin
      res.rdt = '0;
      res.sts = tcb_pkg::TCB_ERR;
    end else begin
      // lane 0 addressed byte, lane 1 top of addressed half
      res.rdt[7:0]   = ref_mem[base + off];
      res.rdt[15:8]  = ref_mem[base + hlf + 1];
      res.rdt[23:16] = ref_mem[base + 2];
      res.rdt[31:24] = ref_mem[base + 3];
      res.sts = tcb_pkg::TCB_OK;
      if (r.wen) begin
        for (int unsigned k = 0; k < (1 << r.siz); k++) begin
          ref_mem[base + off + k] = r.wdt[8*k +: 8];
        end
      end
    end
    return res;
  endfunction

  // one cycle on the falling edge, acc set when the transfer happens
  task automatic drive_cycle(input logic v, input tcb_pkg::tcb_req_t r, output logic acc);
    exp_rsp_t e;
    @(negedge clk);
    exp_vld = 1'b0;
    if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
      e = exp_q.pop_front();
      exp_vld = 1'b1;
      exp_rsp = e.rsp;
    end
    vld = v;
    req = r;
    // rdy only moves on the rising edge
    acc = v && rdy;
    if (acc) begin
      e.due = cyc + HSK_DLY;
      e.rsp = model_access(r);
      exp_q.push_back(e);
    end
  endtask

  // request held until ready
  task automatic xfer(input logic wen, input logic [31:0] adr,
                      input tcb_pkg::tcb_siz_t siz, input logic [31:0] wdt);
    tcb_pkg::tcb_req_t r;
    logic              acc;
    r = '{wen: wen, adr: adr, siz: siz, wdt: wdt};
    acc = 1'b0;
    while (!acc) begin
      drive_cycle(1'b1, r, acc);
    end
    xfer_cnt++;
  endtask

  // idle until every expected response was checked
  task automatic drain();
    logic acc;
    while (exp_q.size() > 0) begin
      drive_cycle(1'b0, '0, acc);
    end
    drive_cycle(1'b0, '0, acc);
  endtask

  task automatic finish_run(input logic timed_out);
    $display("transfers %0d responses %0d errors %0d", xfer_cnt, rsp_cnt, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    logic [31:0]       adr;
    logic [31:0]       dat;
    logic              wen;
    logic [1:0]        off;
    tcb_pkg::tcb_siz_t siz;
    logic [31:0]       wrd_adr [8];
    lfsr = 16'd50927;
    vld = 1'b0;
    req = '0;
    foreach (ref_mem[i]) begin
      ref_mem[i] = 8'h00;
    end
    @(posedge arst_n);
    // whole memory reads zero after the sweep
    test_name = "clear";
    for (int unsigned w = 0; w < MEM_DEPTH; w++) begin
      xfer(1'b0, w * 4, tcb_pkg::SIZ_WORD, rand_bits(32));
    end
    drain();
    test_name = "word";
    for (int i = 0; i < 8; i++) begin
      wrd_adr[i] = rand_bits(IDX_W) * 4;
      xfer(1'b1, wrd_adr[i], tcb_pkg::SIZ_WORD, rand_bits(32));
    end
    for (int i = 0; i < 8; i++) begin
      xfer(1'b0, wrd_adr[i], tcb_pkg::SIZ_WORD, '0);
    end
    drain();
    // bytes at 0..3, halves at 0 and 2, word read after each
    test_name = "subword_write";
    adr = rand_bits(IDX_W) * 4;
    for (int unsigned j = 0; j < 6; j++) begin
      siz = (j < 4) ? tcb_pkg::SIZ_BYTE : tcb_pkg::SIZ_HALF;
      off = (j < 4) ? 2'(j) : 2'(2 * (j - 4));
      xfer(1'b1, adr + off, siz, rand_bits(32));
      xfer(1'b0, adr, tcb_pkg::SIZ_WORD, '0);
    end
    drain();
    test_name = "subword_read";
    adr = rand_bits(IDX_W) * 4;
    xfer(1'b1, adr, tcb_pkg::SIZ_WORD, rand_bits(32));
    for (int unsigned j = 0; j < 6; j++) begin
      siz = (j < 4) ? tcb_pkg::SIZ_BYTE : tcb_pkg::SIZ_HALF;
      off = (j < 4) ? 2'(j) : 2'(2 * (j - 4));
      xfer(1'b0, adr + off, siz, '0);
    end
    drain();
    // out of range, then the word it would alias to
    test_name = "range";
    for (int i = 0; i < 3; i++) begin
      adr = ((1 + rand_bits(3)) * MEM_DEPTH + rand_bits(IDX_W)) * 4;
      xfer(1'b1, adr, tcb_pkg::SIZ_WORD, rand_bits(32));
      xfer(1'b0, adr, tcb_pkg::SIZ_WORD, '0);
      xfer(1'b0, adr & (MEM_DEPTH * 4 - 1), tcb_pkg::SIZ_WORD, '0);
    end
    drain();
    // one transfer per cycle, half of the words out of range
    test_name = "pipeline";
    for (int i = 0; i < 40; i++) begin
      siz = tcb_pkg::tcb_siz_t'(rand_bits(2));
      if (siz == 2'd3) begin
        siz = tcb_pkg::SIZ_WORD;
      end
      off = 2'(rand_bits(2)) & ~((2'd1 << siz) - 2'd1);
      adr = rand_bits(IDX_W + 1) * 4 + off;
      wen = rand_bits(1);
      dat = rand_bits(32);
      xfer(wen, adr, siz, dat);
    end
    drain();
    if (xfer_cnt != rsp_cnt) begin
      errors++;
      $display("response count wrong: %0d transfers but %0d responses", xfer_cnt, rsp_cnt);
    end
    finish_run(1'b0);
  end

endmodule

`default_nettype wire

/* tb/tcb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tcb_clk_gen #(
  parameter int unsigned PERIOD_NS = 100,
  parameter int unsigned RST_CYC   = 16
)(
  output logic clk,
  output logic arst_n
);

  // free running clock, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

  // reset low for RST_CYC periods, released on a falling edge
  initial begin
    arst_n = 1'b0;
    repeat (RST_CYC) @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* verilog/tcb_mem_sys.sv */
`timescale 1ns/1ps
`default_nettype none

module tcb_mem_sys #(
  parameter int unsigned HSK_DLY   = 1,
  parameter int unsigned MEM_DEPTH = 64
)(
  input  wire logic              clk,
  input  wire logic              arst_n,
  // log-size manager port
  input  wire logic              vld,
  input  wire tcb_pkg::tcb_req_t req,
  output logic                   rdy,
  output tcb_pkg::tcb_rsp_t      rsp
);

  ////////////////////
  // byte-enable bus
  ////////////////////

  logic                      ben_vld;
  tcb_ben_pkg::tcb_ben_req_t ben_req;
  logic                      ben_rdy;
  // lane-raw response from the memory
  tcb_pkg::tcb_rsp_t         ben_rsp;

  // log-size to byte-enable conversion
  tcb_logsize2byteena #(
    .HSK_DLY (HSK_DLY)
  ) tcb_logsize2byteena_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .sub_vld (vld),
    .sub_req (req),
    .sub_rdy (rdy),
    .sub_rsp (rsp),
    .man_vld (ben_vld),
    .man_req (ben_req),
    .man_rdy (ben_rdy),
    .man_rsp (ben_rsp)
  );

  // byte-enable SRAM
  tcb_mem_ben #(
    .HSK_DLY   (HSK_DLY),
    .MEM_DEPTH (MEM_DEPTH)
  ) tcb_mem_ben_i (
    .clk    (clk),
    .arst_n (arst_n),
    .vld    (ben_vld),
    .req    (ben_req),
    .rdy    (ben_rdy),
    .rsp    (ben_rsp)
  );

endmodule

`default_nettype wire

/* tcb_mem/tcb_mem_ben.sv */
`timescale 1ns/1ps
`default_nettype none

module tcb_mem_ben #(
  parameter int unsigned HSK_DLY   = 1,
  parameter int unsigned MEM_DEPTH = 64
)(
  input  wire logic                      clk,
  input  wire logic                      arst_n,
  input  wire logic                      vld,
  input  wire tcb_ben_pkg::tcb_ben_req_t req,
  output logic                           rdy,
  output tcb_pkg::tcb_rsp_t              rsp
);

  localparam int unsigned BEN_W  = tcb_ben_pkg::BEN_W;
  localparam int unsigned OFF_W  = tcb_ben_pkg::OFF_W;
  localparam int unsigned BYTE_W = tcb_ben_pkg::BYTE_W;
  localparam int unsigned ADR_W  = tcb_pkg::ADR_W;
  // word index width
  localparam int unsigned IDX_W  = $clog2(MEM_DEPTH);

  // word array, byte lanes packed
  logic [BEN_W-1:0][BYTE_W-1:0] mem [MEM_DEPTH];

  ////////////////////
  // clearing sweep
  ////////////////////

  logic             clr_act;
  logic [IDX_W-1:0] clr_cnt;

  // one word per cycle after reset release
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clr_act <= 1'b1;
      clr_cnt <= '0;
    end else if (clr_act) begin
      clr_cnt <= clr_cnt + 1'b1;
      // last word done
      if (clr_cnt == IDX_W'(MEM_DEPTH - 1)) begin
        clr_act <= 1'b0;
      end
    end
  end

  // no requests accepted while clearing
  assign rdy = ~clr_act;

  ////////////////////
  // access
  ////////////////////

  logic                   trn;
  // word part of the address
  logic [ADR_W-OFF_W-1:0] req_wrd;
  logic [IDX_W-1:0]       req_idx;
  // word inside the array
  logic                   req_rng;

  assign trn     = vld & rdy;
  assign req_wrd = req.adr[ADR_W-1:OFF_W];
  assign req_rng = (req_wrd < MEM_DEPTH);
  assign req_idx = req_wrd[IDX_W-1:0];

  // write port, shared with the sweep
  always_ff @(posedge clk) begin
    if (clr_act) begin
      mem[clr_cnt] <= '0;
    end else if (trn && req.wen && req_rng) begin
      for (int unsigned b = 0; b < BEN_W; b++) begin
        if (req.ben[b]) begin
          mem[req_idx][b] <= req.wdt[b];
        end
      end
    end
  end

  // first response stage
  logic                     rsp_vld_q;
  logic [tcb_pkg::DAT_W-1:0] rsp_rdt_q;
  tcb_pkg::tcb_sts_t        rsp_sts_q;
  tcb_pkg::tcb_rsp_t        rsp_raw;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_vld_q <= 1'b0;
    end else begin
      rsp_vld_q <= trn;
    end
  end

  // read of the old word, zero on a range error
  always_ff @(posedge clk) begin
    if (trn) begin
      rsp_rdt_q <= req_rng ? mem[req_idx] : '0;
      rsp_sts_q <= req_rng ? tcb_pkg::TCB_OK : tcb_pkg::TCB_ERR;
    end
  end

  assign rsp_raw = '{vld: rsp_vld_q, rdt: rsp_rdt_q, sts: rsp_sts_q};

  // remaining stages up to HSK_DLY
  if (HSK_DLY > 1) begin : g_rsp_dly
    tcb_dly_line #(
      .payload_t (tcb_pkg::tcb_rsp_t),
      .DLY       (HSK_DLY - 1)
    ) tcb_dly_line_i (
      .clk    (clk),
      .arst_n (arst_n),
      .din    (rsp_raw),
      .dout   (rsp)
    );
  end else begin : g_rsp_reg
    assign rsp = rsp_raw;
  end

  ////////////////////
  // checks
  ////////////////////

  // memory must be fully swept before the first access
  a_no_trn_clr: assert property (
    @(posedge clk) disable iff (!arst_n)
    trn |-> !clr_act
  ) else $error("tcb_mem_ben: transfer while clearing word %0d", clr_cnt);

endmodule

`default_nettype wire

/* tcb_conv/tcb_logsize2byteena.sv */
`timescale 1ns/1ps
`default_nettype none

module tcb_logsize2byteena #(
  parameter int unsigned HSK_DLY = 1
)(
  input  wire logic                      clk,
  input  wire logic                      arst_n,
  // log-size side, the manager connects here
  input  wire logic                      sub_vld,
  input  wire tcb_pkg::tcb_req_t         sub_req,
  output logic                           sub_rdy,
  output tcb_pkg::tcb_rsp_t              sub_rsp,
  // byte-enable side, the memory connects here
  output logic                           man_vld,
  output tcb_ben_pkg::tcb_ben_req_t      man_req,
  input  wire logic                      man_rdy,
  input  wire tcb_pkg::tcb_rsp_t         man_rsp
);

  localparam int unsigned BEN_W  = tcb_ben_pkg::BEN_W;
  localparam int unsigned OFF_W  = tcb_ben_pkg::OFF_W;
  localparam int unsigned BYTE_W = tcb_ben_pkg::BYTE_W;

  // offset and size kept until the response shows up
  typedef struct packed {
    logic [OFF_W-1:0]  off;
    tcb_pkg::tcb_siz_t siz;
  } dly_t;

  // mask of the offset bits that select lanes for a given size
  // byte -> 11, half -> 10, word -> 00
  function automatic logic [OFF_W-1:0] siz_msk(input tcb_pkg::tcb_siz_t siz);
    logic [OFF_W-1:0] msk;
    for (int unsigned i = 0; i < OFF_W; i++) begin
      msk[i] = (i >= 32'(siz));
    end
    return msk;
  endfunction

  ////////////////////
  // request
  ////////////////////

  // request offset and mask
  logic [OFF_W-1:0]             req_off;
  logic [OFF_W-1:0]             req_msk;
  // write data viewed as lanes
  logic [BEN_W-1:0][BYTE_W-1:0] req_wdt;
  // converted enables and lanes
  logic [BEN_W-1:0]             req_ben;
  logic [BEN_W-1:0][BYTE_W-1:0] req_lne;

  assign req_off = sub_req.adr[OFF_W-1:0];
  assign req_msk = siz_msk(sub_req.siz);
  assign req_wdt = sub_req.wdt;

  for (genvar i = 0; i < BEN_W; i++) begin : g_lane
    localparam logic [OFF_W-1:0] IDX = OFF_W'(i);
    // lane selected when it falls in the addressed block
    assign req_ben[i] = (req_off & req_msk) == (IDX & req_msk);
    // low request bytes repeated over all lanes of the block
    assign req_lne[i] = req_wdt[IDX & ~req_msk];
  end

  // valid passes straight through
  assign man_vld = sub_vld;

  assign man_req = '{
    wen: sub_req.wen,
    adr: sub_req.adr,
    ben: req_ben,
    wdt: req_lne
  };

  ////////////////////
  // response
  ////////////////////

  dly_t             req_dly;
  dly_t             rsp_dly;
  // masked offset used by the read mux
  logic [OFF_W-1:0] rsp_sel;

  assign req_dly = '{off: req_off, siz: sub_req.siz};

  // shifts every cycle, out in step with the response
  tcb_dly_line #(
    .payload_t (dly_t),
    .DLY       (HSK_DLY)
  ) tcb_dly_line_i (
    .clk    (clk),
    .arst_n (arst_n),
    .din    (req_dly),
    .dout   (rsp_dly)
  );

  assign rsp_sel = rsp_dly.off & siz_msk(rsp_dly.siz);

  // read data mux, written for four lanes
  logic [BEN_W-1:0][BYTE_W-1:0] rsp_dtw;
  logic [1:0][BYTE_W-1:0]       rsp_dth;
  logic [BYTE_W-1:0]            rsp_dtb;

  assign rsp_dtw = man_rsp.rdt;
  // addressed half
  assign rsp_dth = rsp_sel[1] ? rsp_dtw[3:2] : rsp_dtw[1:0];
  // addressed byte inside that half
  assign rsp_dtb = rsp_sel[0] ? rsp_dth[1] : rsp_dth[0];

  // upper half unchanged, lane 1 from the half, lane 0 from the byte
  assign sub_rsp = '{
    vld: man_rsp.vld,
    rdt: {rsp_dtw[3:2], rsp_dth[1], rsp_dtb},
    sts: man_rsp.sts
  };

  // ready goes back untouched
  assign sub_rdy = man_rdy;

  ////////////////////
  // checks
  ////////////////////

  // size 3 would need more lanes than the bus has
  a_siz_legal: assert property (
    @(posedge clk) disable iff (!arst_n)
    sub_vld |-> (sub_req.siz <= tcb_pkg::SIZ_MAX)
  ) else $error("tcb_logsize2byteena: illegal size %0d", sub_req.siz);

  // misaligned access, the conversion only handles aligned blocks
  a_adr_aligned: assert property (
    @(posedge clk) disable iff (!arst_n)
    sub_vld |-> ((req_off & ~req_msk) == '0)
  ) else $error("tcb_logsize2byteena: address 0x%08h not aligned to size %0d",
                sub_req.adr, sub_req.siz);

endmodule

`default_nettype wire

/* verilog/tcb_dly_line.sv */
`timescale 1ns/1ps
`default_nettype none

module tcb_dly_line #(
  parameter type         payload_t = logic,
  parameter int unsigned DLY       = 1
)(
  input  wire logic     clk,
  input  wire logic     arst_n,
  input  wire payload_t din,
  output payload_t      dout
);

  // one register per stage, stage 0 takes din
  payload_t dly_q [DLY];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dly_q <= '{default: '0};
    end else begin
      dly_q[0] <= din;
      // shift by one stage every cycle
      for (int unsigned i = 1; i < DLY; i++) begin
        dly_q[i] <= dly_q[i-1];
      end
    end
  end

  // last stage
  assign dout = dly_q[DLY-1];

  ////////////////////
  // checks
  ////////////////////

  // a zero length line would pass data through without a register
  a_dly_min: assert property (@(posedge clk) DLY >= 1)
    else $error("tcb_dly_line: DLY = %0d is below 1", DLY);

endmodule

`default_nettype wire

/* common/tcb_ben_pkg.sv */
`default_nettype none

package tcb_ben_pkg;

  ////////////////////
  // byte lanes
  ////////////////////

  // bits per byte lane
  localparam int unsigned BYTE_W = 8;
  // number of byte lanes, 4 on a 32-bit bus
  localparam int unsigned BEN_W  = tcb_pkg::DAT_W / BYTE_W;
  // address offset width inside a word
  localparam int unsigned OFF_W  = $clog2(BEN_W);

  // byte-enable request
  typedef struct packed {
    // write enable
    logic                         wen;
    // byte address, copied from the log-size side
    logic [tcb_pkg::ADR_W-1:0]    adr;
    // one enable bit per lane
    logic [BEN_W-1:0]             ben;
    // write data, lane i lands on byte i of the word
    logic [BEN_W-1:0][BYTE_W-1:0] wdt;
  } tcb_ben_req_t;

endpackage

`default_nettype wire

/* common/tcb_pkg.sv */
`default_nettype none

package tcb_pkg;

  ////////////////////
  // bus geometry
  ////////////////////

  // address width in bits
  localparam int unsigned ADR_W = 32;
  // data width in bits, only 32 is supported
  localparam int unsigned DAT_W = 32;

  ////////////////////
  // size encoding
  ////////////////////

  // log2 of the byte count
  // value 3 is not a legal size
  typedef logic [1:0] tcb_siz_t;

  localparam tcb_siz_t SIZ_BYTE = 2'd0;
  localparam tcb_siz_t SIZ_HALF = 2'd1;
  localparam tcb_siz_t SIZ_WORD = 2'd2;
  // largest legal size on a 32-bit bus
  localparam tcb_siz_t SIZ_MAX  = SIZ_WORD;

  // response status
  typedef enum logic {
    TCB_OK  = 1'b0,
    TCB_ERR = 1'b1
  } tcb_sts_t;

  ////////////////////
  // transfer structs
  ////////////////////

  // log-size request
  typedef struct packed {
    // write enable
    logic             wen;
    // byte address
    logic [ADR_W-1:0] adr;
    // log2 size
    tcb_siz_t         siz;
    // write data, byte 0 is the lowest addressed byte
    logic [DAT_W-1:0] wdt;
  } tcb_req_t;

  // response, no back-pressure
  typedef struct packed {
    logic             vld;
    logic [DAT_W-1:0] rdt;
    tcb_sts_t         sts;
  } tcb_rsp_t;

endpackage

`default_nettype wire
